//--- logic/mem_pkg.sv
// ======================================================================
// shared widths, address map, funct3 codes and bus structs
// ram occupies 0 .. ram_bytes-1, peripheral is a 16 byte window
// periph_wait must be at least 1
// ======================================================================
`default_nettype none

package mem_pkg;

    localparam int xlen = 32;

    // address map
    localparam int ram_bytes = 2048;
    localparam int ram_words = ram_bytes / 4;
    localparam logic [xlen-1:0] periph_base = 32'h0001_0000;
    localparam int periph_regs_n = 4;
    localparam int periph_wait = 3;                    // wait cycles before rsp
    localparam int periph_cnt_w = $clog2(periph_wait + 1);

    // load codes
    localparam logic [2:0] f3_lb  = 3'd0;
    localparam logic [2:0] f3_lh  = 3'd1;
    localparam logic [2:0] f3_lw  = 3'd2;
    localparam logic [2:0] f3_lbu = 3'd4;
    localparam logic [2:0] f3_lhu = 3'd5;

    // store codes, same encoding space as loads
    localparam logic [2:0] f3_sb = 3'd0;
    localparam logic [2:0] f3_sh = 3'd1;
    localparam logic [2:0] f3_sw = 3'd2;

    // core data request, 68 bits
    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;   // unplaced, lane 0 aligned
        logic [2:0]      funct3;
        logic            we;
    } lsu_req_t;

    // bus request, 69 bits
    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;   // already lane placed
        logic [3:0]      be;
        logic            we;
    } mem_req_t;

    typedef struct packed {
        logic [xlen-1:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- logic/lsu_align.sv
// ======================================================================
// store lane placement and load extraction, purely combinational
// misaligned low address bits are ignored, no trap
// ======================================================================
`default_nettype none

module lsu_align (
    input  logic [2:0]  funct3,
    input  logic [1:0]  addr_lo,
    input  logic [31:0] wdata,
    input  logic [31:0] rdata,
    output logic [3:0]  be,
    output logic [31:0] lane_wdata,
    output logic [31:0] load_data
);
    import mem_pkg::*;

    logic [xlen-1:0] byte_sh;   // selected byte moved to lane 0
    logic [xlen-1:0] half_sh;   // selected half moved to lane 0

    // stores: replicate across lanes, be picks the live ones
    always_comb begin
        case (funct3)
            f3_sb: begin
                lane_wdata = {4{wdata[7:0]}};
                be         = 4'b0001 << addr_lo;
            end
            f3_sh: begin
                lane_wdata = {2{wdata[15:0]}};
                be         = addr_lo[1] ? 4'b1100 : 4'b0011;  // bit 0 ignored
            end
            default: begin   // sw and anything else
                lane_wdata = wdata;
                be         = 4'b1111;
            end
        endcase
    end

    assign byte_sh = rdata >> {addr_lo, 3'b000};
    assign half_sh = rdata >> {addr_lo[1], 4'b0000};

    // loads: shift down, then extend
    always_comb begin
        case (funct3)
            f3_lb:   load_data = {{24{byte_sh[7]}}, byte_sh[7:0]};
            f3_lh:   load_data = {{16{half_sh[15]}}, half_sh[15:0]};
            f3_lbu:  load_data = {24'b0, byte_sh[7:0]};
            f3_lhu:  load_data = {16'b0, half_sh[15:0]};
            default: load_data = rdata;   // lw, pass through
        endcase
    end

endmodule

`default_nettype wire

//--- logic/mem_handler.sv
// ======================================================================
// serves fetch and data requests one at a time over one bus
// data wins over a waiting fetch; stores give no response pulse
// requests must stay stable until accepted
// ======================================================================
`default_nettype none

module mem_handler (
    input  logic              clk,
    input  logic              nrst,
    // fetch channel
    input  logic              fetch_valid,
    input  logic [31:0]       fetch_pc,
    output logic              fetch_ready,
    // data channel
    input  logic              data_valid,
    input  mem_pkg::lsu_req_t data_req,
    output logic              data_ready,
    // responses to core
    output logic              inst_valid,
    output logic [31:0]       inst,
    output logic              load_valid,
    output logic [31:0]       load_data,
    // bus side
    output logic              bus_valid,
    output mem_pkg::mem_req_t bus_req,
    input  logic              bus_ready,
    input  logic              bus_rsp_valid,
    input  mem_pkg::mem_rsp_t bus_rsp
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_issue,      // bus_valid high, waiting for bus_ready
        st_wait_rsp    // handshake done, waiting for bus_rsp_valid
    } state_t;

    state_t          state;
    state_t          state_nxt;
    lsu_req_t        req_q;       // latched request
    logic            is_data_q;   // kind of request in flight
    logic            idle;
    logic            take_data;
    logic            take_fetch;
    logic            rsp_done;
    logic [3:0]      lane_be;
    logic [xlen-1:0] lane_wdata;
    logic [xlen-1:0] load_ext;

    assign idle        = (state == st_idle);
    assign data_ready  = idle;
    assign fetch_ready = idle && !data_valid;  // data has priority
    assign take_data   = data_valid && data_ready;
    assign take_fetch  = fetch_valid && fetch_ready;
    assign rsp_done    = (state == st_wait_rsp) && bus_rsp_valid;

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (take_data || take_fetch) begin
                    state_nxt = st_issue;
                end
            end
            st_issue: begin
                if (bus_ready) begin
                    state_nxt = st_wait_rsp;
                end
            end
            st_wait_rsp: begin
                if (bus_rsp_valid) begin
                    state_nxt = st_idle;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    // control state
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state      <= st_idle;
            is_data_q  <= 1'b0;
            load_valid <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            state <= state_nxt;
            if (take_data || take_fetch) begin
                is_data_q <= take_data;
            end
            // one cycle pulses, lined up with return to idle
            load_valid <= rsp_done && is_data_q && !req_q.we;
            inst_valid <= rsp_done && !is_data_q;
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (take_data) begin
            req_q <= data_req;
        end else if (take_fetch) begin
            // fetch looks like an lw to the aligner
            req_q <= '{addr: fetch_pc, wdata: '0, funct3: f3_lw, we: 1'b0};
        end
        if (rsp_done) begin
            load_data <= load_ext;
            inst      <= bus_rsp.rdata;   // raw word
        end
    end

    // lane placement and load extension off the latched request
    lsu_align lsu_align_i (
        .funct3     (req_q.funct3),
        .addr_lo    (req_q.addr[1:0]),
        .wdata      (req_q.wdata),
        .rdata      (bus_rsp.rdata),
        .be         (lane_be),
        .lane_wdata (lane_wdata),
        .load_data  (load_ext)
    );

    assign bus_valid = (state == st_issue);

    always_comb begin
        bus_req.addr  = req_q.addr;
        bus_req.wdata = lane_wdata;
        bus_req.be    = lane_be;       // 4'hf for fetch and lw
        bus_req.we    = is_data_q && req_q.we;
    end

endmodule

`default_nettype wire

//--- logic/bus_decoder.sv
// ======================================================================
// address decode for ram, peripheral window and unmapped space
// unmapped reads return zero one cycle later, writes are dropped
// one request at a time; stalls while the peripheral is busy
// ======================================================================
`default_nettype none

module bus_decoder (
    input  logic              clk,
    input  logic              nrst,
    input  logic              bus_valid,
    input  mem_pkg::mem_req_t bus_req,
    output logic              bus_ready,
    output logic              bus_rsp_valid,
    output mem_pkg::mem_rsp_t bus_rsp,
    output logic              ram_sel,
    output logic              periph_sel,
    output mem_pkg::mem_req_t tgt_req,
    input  logic              ram_rsp_valid,
    input  logic [31:0]       ram_rdata,
    input  logic              periph_rsp_valid,
    input  logic [31:0]       periph_rdata
);
    import mem_pkg::*;

    logic ram_hit;
    logic periph_hit;
    logic hs;            // bus handshake
    logic periph_busy;
    logic umap_rsp_q;    // self answer for unmapped space

    assign ram_hit    = bus_req.addr < xlen'(ram_bytes);
    assign periph_hit = (bus_req.addr >= periph_base) &&
                        (bus_req.addr < periph_base + xlen'(periph_regs_n * 4));

    assign bus_ready  = !periph_busy;
    assign hs         = bus_valid && bus_ready;
    assign ram_sel    = hs && ram_hit;
    assign periph_sel = hs && periph_hit;
    assign tgt_req    = bus_req;   // shared by both targets

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            periph_busy <= 1'b0;
            umap_rsp_q  <= 1'b0;
        end else begin
            if (periph_sel) begin
                periph_busy <= 1'b1;
            end else if (periph_rsp_valid) begin
                periph_busy <= 1'b0;
            end
            umap_rsp_q <= hs && !ram_hit && !periph_hit;
        end
    end

    // at most one source is valid at a time
    assign bus_rsp_valid = ram_rsp_valid || periph_rsp_valid || umap_rsp_q;

    always_comb begin
        if (ram_rsp_valid) begin
            bus_rsp.rdata = ram_rdata;
        end else if (periph_rsp_valid) begin
            bus_rsp.rdata = periph_rdata;
        end else begin
            bus_rsp.rdata = '0;   // unmapped or idle
        end
    end

endmodule

`default_nettype wire

//--- logic/data_ram.sv
// ======================================================================
// word wide data ram with byte enables, fixed one cycle response
// contents are not cleared by reset
// rdata shows the word as it was before a write in the same access
// ======================================================================
`default_nettype none

module data_ram (
    input  logic              clk,
    input  logic              sel,
    input  mem_pkg::mem_req_t req,
    output logic              rsp_valid,
    output logic [31:0]       rdata
);
    import mem_pkg::*;

    localparam int idx_w = $clog2(ram_words);

    logic [xlen-1:0]  mem [ram_words];
    logic [idx_w-1:0] idx;

    assign idx = req.addr[idx_w+1:2];   // word index, addr bits 10:2

    // response strobe follows sel by one cycle
    always_ff @(posedge clk) begin
        rsp_valid <= sel;
    end

    always_ff @(posedge clk) begin
        if (sel) begin
            rdata <= mem[idx];   // old word
            if (req.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (req.be[b]) begin
                        mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/periph_regs.sv
// ======================================================================
// four word registers standing in for a slow peripheral
// response comes periph_wait+1 cycles after sel, one access at a time
// read data is the register value from before the write
// ======================================================================
`default_nettype none

module periph_regs (
    input  logic              clk,
    input  logic              nrst,
    input  logic              sel,
    input  mem_pkg::mem_req_t req,
    output logic              rsp_valid,
    output logic [31:0]       rdata
);
    import mem_pkg::*;

    localparam int idx_w = $clog2(periph_regs_n);

    logic [xlen-1:0]         regs [periph_regs_n];
    logic [idx_w-1:0]        idx;
    logic [periph_cnt_w-1:0] cnt;      // remaining wait cycles
    logic [xlen-1:0]         hold_q;   // captured read value

    assign idx   = req.addr[idx_w+1:2];   // addr bits 3:2
    assign rdata = hold_q;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int r = 0; r < periph_regs_n; r++) begin
                regs[r] <= '0;
            end
            cnt       <= '0;
            rsp_valid <= 1'b0;
        end else begin
            if (sel && req.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (req.be[b]) begin
                        regs[idx][8*b +: 8] <= req.wdata[8*b +: 8];
                    end
                end
            end
            if (sel) begin
                cnt <= periph_cnt_w'(periph_wait);   // start countdown
            end else if (cnt != '0) begin
                cnt <= cnt - periph_cnt_w'(1);
            end
            rsp_valid <= (cnt == periph_cnt_w'(1));  // last wait cycle
        end
    end

    // payload capture at select time
    always_ff @(posedge clk) begin
        if (sel) begin
            hold_q <= regs[idx];
        end
    end

endmodule

`default_nettype wire

//--- logic/mem_subsys_top.sv
// ======================================================================
// memory access unit top: handler, decoder, ram and peripheral
// ram and unmapped loads take 3 cycles, peripheral loads take 6
// ======================================================================
`default_nettype none

module mem_subsys_top (
    input  logic              clk,
    input  logic              nrst,
    input  logic              fetch_valid,
    input  logic [31:0]       fetch_pc,
    output logic              fetch_ready,
    input  logic              data_valid,
    input  mem_pkg::lsu_req_t data_req,
    output logic              data_ready,
    output logic              inst_valid,
    output logic [31:0]       inst,
    output logic              load_valid,
    output logic [31:0]       load_data
);
    import mem_pkg::*;

    // handler to decoder
    logic            bus_valid;
    mem_req_t        bus_req;
    logic            bus_ready;
    logic            bus_rsp_valid;
    mem_rsp_t        bus_rsp;
    // decoder to targets
    logic            ram_sel;
    logic            periph_sel;
    mem_req_t        tgt_req;
    logic            ram_rsp_valid;
    logic [xlen-1:0] ram_rdata;
    logic            periph_rsp_valid;
    logic [xlen-1:0] periph_rdata;

    mem_handler mem_handler_i (
        .clk           (clk),
        .nrst          (nrst),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc),
        .fetch_ready   (fetch_ready),
        .data_valid    (data_valid),
        .data_req      (data_req),
        .data_ready    (data_ready),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .load_valid    (load_valid),
        .load_data     (load_data),
        .bus_valid     (bus_valid),
        .bus_req       (bus_req),
        .bus_ready     (bus_ready),
        .bus_rsp_valid (bus_rsp_valid),
        .bus_rsp       (bus_rsp)
    );

    bus_decoder bus_decoder_i (
        .clk              (clk),
        .nrst             (nrst),
        .bus_valid        (bus_valid),
        .bus_req          (bus_req),
        .bus_ready        (bus_ready),
        .bus_rsp_valid    (bus_rsp_valid),
        .bus_rsp          (bus_rsp),
        .ram_sel          (ram_sel),
        .periph_sel       (periph_sel),
        .tgt_req          (tgt_req),
        .ram_rsp_valid    (ram_rsp_valid),
        .ram_rdata        (ram_rdata),
        .periph_rsp_valid (periph_rsp_valid),
        .periph_rdata     (periph_rdata)
    );

    data_ram data_ram_i (
        .clk       (clk),
        .sel       (ram_sel),
        .req       (tgt_req),
        .rsp_valid (ram_rsp_valid),
        .rdata     (ram_rdata)
    );

    periph_regs periph_regs_i (
        .clk       (clk),
        .nrst      (nrst),
        .sel       (periph_sel),
        .req       (tgt_req),
        .rsp_valid (periph_rsp_valid),
        .rdata     (periph_rdata)
    );

endmodule

`default_nettype wire

//--- sim/tb_mem_subsys.sv
// ======================================================================
// random load, store and fetch traffic against ram, peripheral, unmapped
// ram words are only read back after a full sw, ram is not reset
// ======================================================================
`default_nettype none

module tb_mem_subsys;
    timeunit 1ns;
    timeprecision 100ps;
    import mem_pkg::*;

    localparam int max_wait   = 50;   // cycles per wait loop
    localparam int sel_dready = 0;
    localparam int sel_fready = 1;
    localparam int sel_load   = 2;
    localparam int sel_inst   = 3;

    logic        clk;
    logic        nrst;
    logic        fetch_valid;
    logic [31:0] fetch_pc;
    logic        fetch_ready;
    logic        data_valid;
    lsu_req_t    data_req;
    logic        data_ready;
    logic        inst_valid;
    logic [31:0] inst;
    logic        load_valid;
    logic [31:0] load_data;

    logic [7:0]  ram_m [ram_bytes];        // byte model of the ram
    logic [7:0]  per_m [periph_regs_n*4];  // byte model of the registers
    logic [31:0] written [$];              // ram words holding known data
    logic [31:0] exp_data;
    logic [31:0] exp_inst;
    logic        exp_ram_lat;   // expect the fixed ram latency
    logic        rst_chk;
    logic        prio_mode;
    logic        wait_rsp;      // load or fetch accepted, pulse pending
    logic        ld_done;
    int          lat;           // cycles since accept
    int          assert_errs = 0;
    int          wait_errs   = 0;
    int          tests_ok    = 0;
    int          tests_bad   = 0;
    int          loads_done  = 0;
    int          stores_done = 0;

    mem_subsys_top mem_subsys_top_i (
        .clk         (clk),
        .nrst        (nrst),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_ready (fetch_ready),
        .data_valid  (data_valid),
        .data_req    (data_req),
        .data_ready  (data_ready),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .load_valid  (load_valid),
        .load_data   (load_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    // in-flight tracking, seen from the core side
    always @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wait_rsp <= 1'b0;
            lat      <= 0;
            ld_done  <= 1'b0;
        end else begin
            if ((data_valid && data_ready && !data_req.we) || (fetch_valid && fetch_ready)) begin
                wait_rsp <= 1'b1;
                lat      <= 1;
            end else if (load_valid || inst_valid) begin
                wait_rsp <= 1'b0;
            end else if (wait_rsp) begin
                lat <= lat + 1;
            end
            if (!prio_mode || (data_valid && data_ready)) begin
                ld_done <= 1'b0;   // rearmed by each competing load
            end else if (load_valid) begin
                ld_done <= 1'b1;   // load came back first
            end
        end
    end

    rst_ready: assert property (@(posedge clk) disable iff (!nrst)
        rst_chk |-> data_ready && fetch_ready)
        else begin
            $display("ready signals not both high after reset");
            assert_errs++;
        end
    no_stray: assert property (@(posedge clk) disable iff (!nrst)
        !wait_rsp |-> !load_valid && !inst_valid)
        else begin
            $display("response pulse without an accepted load or fetch");
            assert_errs++;
        end
    busy_low: assert property (@(posedge clk) disable iff (!nrst)
        wait_rsp && !load_valid && !inst_valid |-> !data_ready && !fetch_ready)
        else begin
            $display("a ready signal went high while an access was in flight");
            assert_errs++;
        end
    data_first: assert property (@(posedge clk) disable iff (!nrst)
        data_valid && fetch_valid && data_ready |-> !fetch_ready)
        else begin
            $display("fetch_ready high while a data request was waiting");
            assert_errs++;
        end
    load_order: assert property (@(posedge clk) disable iff (!nrst)
        inst_valid && prio_mode |-> ld_done)
        else begin
            $display("instruction returned before the competing load");
            assert_errs++;
        end
    load_value: assert property (@(posedge clk) disable iff (!nrst)
        load_valid |-> load_data == exp_data)
        else begin
            $display("[FAIL] load_data got %h exp %h", $sampled(load_data), $sampled(exp_data));
            assert_errs++;
        end
    inst_value: assert property (@(posedge clk) disable iff (!nrst)
        inst_valid |-> inst == exp_inst)
        else begin
            $display("[FAIL] inst got %h exp %h", $sampled(inst), $sampled(exp_inst));
            assert_errs++;
        end
    ram_latency: assert property (@(posedge clk) disable iff (!nrst)
        (load_valid || inst_valid) && exp_ram_lat |-> lat == 3)
        else begin
            $display("[FAIL] latency got %h exp %h", $sampled(lat), 3);
            assert_errs++;
        end

    function automatic int region_of(input logic [31:0] a);
        if (a < 32'(ram_bytes)) return 0;
        if (a >= periph_base && a < periph_base + 32'(periph_regs_n * 4)) return 1;
        return 2;   // unmapped
    endfunction

    function automatic logic [7:0] ref_byte(input logic [31:0] a);
        case (region_of(a))
            0:       return ram_m[a[10:0]];
            1:       return per_m[a[3:0]];
            default: return 8'h00;   // unmapped reads as zero
        endcase
    endfunction

    task automatic poke_byte(input logic [31:0] a, input logic [7:0] b);
        case (region_of(a))
            0:       ram_m[a[10:0]] = b;
            1:       per_m[a[3:0]] = b;
            default: ;   // write dropped
        endcase
    endtask

    // access size from funct3 low bits, low address bits ignored
    task automatic apply_store(input logic [31:0] a, input logic [31:0] d, input logic [2:0] f3);
        int          nb;
        logic [31:0] base;
        nb   = 1 << f3[1:0];
        base = a & ~(32'(nb) - 32'd1);
        for (int i = 0; i < nb; i++) begin
            poke_byte(base + 32'(i), d[8*i +: 8]);
        end
    endtask

    function automatic logic [31:0] predict_load(input logic [31:0] a, input logic [2:0] f3);
        int          nb;
        logic [31:0] base;
        logic [31:0] v;
        nb   = 1 << f3[1:0];
        base = a & ~(32'(nb) - 32'd1);
        v    = '0;
        for (int i = 0; i < nb; i++) begin
            v[8*i +: 8] = ref_byte(base + 32'(i));
        end
        if (!f3[2] && nb == 1 && v[7]) v[31:8] = '1;     // lb sign fill
        if (!f3[2] && nb == 2 && v[15]) v[31:16] = '1;   // lh sign fill
        return v;
    endfunction

    function automatic logic probe(input int sel);
        case (sel)
            sel_dready: return data_ready;
            sel_fready: return fetch_ready;
            sel_load:   return load_valid;
            default:    return inst_valid;
        endcase
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;   // drive and look just after the edge
    endtask

    task automatic wait_for(input int sel, input string what);
        int n;
        n = 0;
        while (!probe(sel) && n < max_wait) begin
            tick();
            n++;
        end
        if (!probe(sel)) begin
            $display("timeout waiting for %s", what);
            wait_errs++;
        end
    endtask

    // hold the request until the edge that accepts it
    task automatic issue_data(input logic [31:0] a, input logic [31:0] d,
                              input logic [2:0] f3, input logic we);
        data_req   = '{addr: a, wdata: d, funct3: f3, we: we};
        data_valid = 1'b1;
        wait_for(sel_dready, "data_ready");
        tick();
        data_valid = 1'b0;
    endtask

    task automatic store_req(input logic [31:0] a, input logic [31:0] d, input logic [2:0] f3);
        apply_store(a, d, f3);
        issue_data(a, d, f3, 1'b1);
        wait_for(sel_dready, "data_ready after store");
        stores_done++;
    endtask

    task automatic check_load(input logic [31:0] a, input logic [2:0] f3, input logic ram_lat);
        exp_data    = predict_load(a, f3);
        exp_ram_lat = ram_lat;
        issue_data(a, 32'h0, f3, 1'b0);
        wait_for(sel_load, "load_valid");
        tick();   // expectation held over the sampling edge
        loads_done++;
    endtask

    // load and fetch raised together, load must win
    task automatic run_priority(input logic [31:0] ld_addr, input logic [31:0] pc);
        exp_data    = predict_load(ld_addr, f3_lw);
        exp_inst    = predict_load(pc, f3_lw);
        exp_ram_lat = 1'b1;
        prio_mode   = 1'b1;
        fetch_pc    = pc;
        fetch_valid = 1'b1;
        issue_data(ld_addr, 32'h0, f3_lw, 1'b0);
        wait_for(sel_load, "load_valid");
        wait_for(sel_fready, "fetch_ready");
        tick();
        fetch_valid = 1'b0;
        wait_for(sel_inst, "inst_valid");
        tick();
        prio_mode = 1'b0;
    endtask

    function automatic logic [31:0] rand_ram_word();
        logic [31:0] r;
        r = $urandom;
        return {21'b0, r[8:0], 2'b00};
    endfunction

    task automatic close_test(input string name, input int errs_at_start);
        if (assert_errs + wait_errs == errs_at_start) begin
            $display("test %s: ok", name);
            tests_ok++;
        end else begin
            $display("test %s: FAILED", name);
            tests_bad++;
        end
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] r;
        int          errs0;
        r           = $urandom(32'ha986);
        nrst        = 1'b0;
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        data_valid  = 1'b0;
        data_req    = '0;
        exp_data    = '0;
        exp_inst    = '0;
        exp_ram_lat = 1'b0;
        rst_chk     = 1'b0;
        prio_mode   = 1'b0;
        foreach (per_m[i]) per_m[i] = 8'h00;   // registers reset to zero
        repeat (2) @(posedge clk);
        #1 nrst = 1'b1;

        errs0   = assert_errs + wait_errs;
        rst_chk = 1'b1;
        repeat (4) tick();   // idle window, no pulses allowed
        rst_chk = 1'b0;
        close_test("reset state", errs0);

        errs0 = assert_errs + wait_errs;
        for (int k = 0; k < 6; k++) begin
            a = rand_ram_word();
            written.push_back(a);
            store_req(a, $urandom, f3_sw);
            check_load(a, f3_lw, 1'b1);
        end
        close_test("ram word round trip", errs0);

        errs0 = assert_errs + wait_errs;
        for (int k = 0; k < 6; k++) begin
            a = rand_ram_word();
            written.push_back(a);
            store_req(a, $urandom, f3_sw);
            r = $urandom;   // lane offsets
            store_req(a | {30'b0, r[1:0]}, $urandom, f3_sb);
            store_req(a | {30'b0, r[2], 1'b0}, $urandom, f3_sh);
            check_load(a | {30'b0, r[4:3]}, f3_lb, 1'b1);
            check_load(a | {30'b0, r[6:5]}, f3_lbu, 1'b1);
            check_load(a | {30'b0, r[7], 1'b0}, f3_lh, 1'b1);
            check_load(a | {30'b0, r[8], 1'b0}, f3_lhu, 1'b1);
            check_load(a, f3_lw, 1'b1);
        end
        close_test("byte and halfword", errs0);

        errs0 = assert_errs + wait_errs;
        for (int k = 0; k < 4; k++) begin
            run_priority(written[k], written[k+2]);
        end
        close_test("data over fetch", errs0);

        errs0 = assert_errs + wait_errs;
        for (int k = 0; k < periph_regs_n; k++) begin
            a = periph_base + 32'(4 * k);
            store_req(a, $urandom, f3_sw);
            check_load(a, f3_lw, 1'b0);   // wait states, no fixed latency
            r = $urandom;
            store_req(a | {30'b0, r[1:0]}, $urandom, f3_sb);
            store_req(a | {30'b0, r[2], 1'b0}, $urandom, f3_sh);
            check_load(a | {30'b0, r[4:3]}, f3_lb, 1'b0);
            check_load(a | {30'b0, r[5], 1'b0}, f3_lhu, 1'b0);
        end
        close_test("peripheral", errs0);

        errs0 = assert_errs + wait_errs;
        check_load(32'h0002_0040, f3_lw, 1'b0);
        a = written[0];
        store_req(32'h0000_0800 | a, $urandom, f3_sw);      // would alias a ram word
        store_req(periph_base + 32'h10, $urandom, f3_sw);   // just past the registers
        check_load(32'h0000_0800 | a, f3_lw, 1'b0);
        foreach (written[i]) check_load(written[i], f3_lw, 1'b1);
        for (int k = 0; k < periph_regs_n; k++) begin
            check_load(periph_base + 32'(4 * k), f3_lw, 1'b0);
        end
        close_test("unmapped region", errs0);

        $display("tests ok %0d failed %0d, loads %0d, stores %0d, errors %0d",
                 tests_ok, tests_bad, loads_done, stores_done, assert_errs + wait_errs);
        if (tests_bad == 0 && assert_errs + wait_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
logic/mem_pkg.sv
logic/lsu_align.sv
logic/mem_handler.sv
logic/bus_decoder.sv
logic/data_ram.sv
logic/periph_regs.sv
logic/mem_subsys_top.sv
sim/tb_mem_subsys.sv

//--- Makefile
# Verilator build and run for the memory access unit testbench
LOG = sim.log
TOP = tb_mem_subsys

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
